// ==== tb.f ====
source/branch_pkg.sv
source/brcfg_pkg.sv
source/branch_compare.sv
source/branch_unit.sv
source/branch_cfg_regs.sv
source/branch_resolve_top.sv
verification/tb_branch_resolve.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch resolution testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_branch_resolve -f tb.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_branch_resolve > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== verification/tb_branch_resolve.sv ====
`timescale 1ns/1ps

module tb_branch_resolve
  import branch_pkg::*, brcfg_pkg::*;
();

  localparam int unsigned WB_TIMEOUT    = 16;
  localparam int unsigned DRAIN_TIMEOUT = 32;

  // Expected outcome of one issued instruction
  typedef struct packed {
    logic            taken;
    logic [VLEN-1:0] pc;
    logic [VLEN-1:0] target;
    logic [VLEN-1:0] link;
    logic            mis;
    logic [CF_W-1:0] cf;
    logic            exc;
    logic [VLEN-1:0] tval;
  } exp_t;

  logic clk_i;
  logic rst_n_i;
  logic valid_i;
  logic [OP_W-1:0] op_i;
  logic [VLEN-1:0] operand_a_i;
  logic [VLEN-1:0] operand_b_i;
  logic [VLEN-1:0] imm_i;
  logic [VLEN-1:0] pc_i;
  logic is_compressed_i;
  logic [CF_W-1:0] pred_cf_i;
  logic [VLEN-1:0] pred_addr_i;
  logic res_valid_o;
  logic [VLEN-1:0] res_pc_o;
  logic [VLEN-1:0] res_target_o;
  logic res_taken_o;
  logic res_mispredict_o;
  logic [CF_W-1:0] res_cf_o;
  logic [VLEN-1:0] link_o;
  logic exc_valid_o;
  logic [CAUSE_W-1:0] exc_cause_o;
  logic [VLEN-1:0] exc_tval_o;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  logic [WB_ADR_W-1:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic wb_ack_o;

  // Reference queue with one entry per issued instruction
  exp_t ref_q[$];
  exp_t cur_exp;
  logic chk = 1'b0;
  // Shadow of the control register and event tallies
  logic rvc_model = 1'b1;
  logic tval_model = 1'b1;
  int unsigned n_resolved = 0;
  int unsigned n_mispred = 0;

  branch_resolve_top u_branch_resolve_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic fail_now(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "Stopped on a timeout");
  endtask

  // Expected result from the resolution rules
  function automatic exp_t predict(input logic [OP_W-1:0] op, input logic [VLEN-1:0] a,
                                   input logic [VLEN-1:0] b, input logic [VLEN-1:0] imm,
                                   input logic [VLEN-1:0] pc, input logic comp,
                                   input logic [CF_W-1:0] pcf, input logic [VLEN-1:0] paddr);
    exp_t e;
    logic [VLEN-1:0] tgt;
    case (op)
      OP_BEQ:  e.taken = (a == b);
      OP_BNE:  e.taken = (a != b);
      OP_BLT:  e.taken = ($signed(a) < $signed(b));
      OP_BGE:  e.taken = ($signed(a) >= $signed(b));
      OP_BLTU: e.taken = (a < b);
      OP_BGEU: e.taken = (a >= b);
      default: e.taken = 1'b1;
    endcase
    tgt = ((op == OP_JALR) ? a : pc) + imm;
    if (op == OP_JALR) begin
      tgt[0] = 1'b0;
    end
    e.pc = pc;
    e.link = pc + (comp ? 32'd2 : 32'd4);
    e.target = e.taken ? tgt : e.link;
    if (op <= OP_BGEU) begin
      e.cf = CF_BRANCH;
      e.mis = e.taken != (pcf == CF_BRANCH);
    end else if (op == OP_JALR) begin
      e.mis = (pcf == CF_NONE) || (paddr != tgt);
      e.cf = (e.mis && (pcf != CF_RETURN)) ? CF_JUMPR : pcf;
    end else begin
      e.cf = pcf;
      e.mis = 1'b0;
    end
    e.exc = !rvc_model && e.taken && (tgt[1:0] != 2'b00);
    e.tval = tval_model ? pc : '0;
    return e;
  endfunction

  task automatic issue(input logic [OP_W-1:0] op, input logic [VLEN-1:0] a,
                       input logic [VLEN-1:0] b, input logic [VLEN-1:0] imm,
                       input logic [VLEN-1:0] pc, input logic comp,
                       input logic [CF_W-1:0] pcf, input logic [VLEN-1:0] paddr);
    exp_t e;
    @(posedge clk_i);
    valid_i <= 1'b1;
    op_i <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    imm_i <= imm;
    pc_i <= pc;
    is_compressed_i <= comp;
    pred_cf_i <= pcf;
    pred_addr_i <= paddr;
    e = predict(op, a, b, imm, pc, comp, pcf, paddr);
    ref_q.push_back(e);
    n_resolved++;
    if (e.mis) begin
      n_mispred++;
    end
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  // Wait until every issued instruction has been checked
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        stop_on_timeout("the result pipeline to drain");
      end
    end while ((ref_q.size() != 0) || res_valid_o);
  endtask

  task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned waited;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdata;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WB_TIMEOUT) begin
        stop_on_timeout("the Wishbone ack");
      end
    end while (!wb_ack_o);
    rdata = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i <= 1'b0;
  endtask

  task automatic write_ctrl(input logic [1:0] bits);
    logic [31:0] unused;
    wb_access(1'b1, ADR_CTRL, {30'd0, bits}, unused);
    rvc_model = bits[CTRL_RVC_BIT];
    tval_model = bits[CTRL_TVAL_BIT];
  endtask

  task automatic read_check(input logic [WB_ADR_W-1:0] adr, input logic [31:0] exp,
                            input string name);
    logic [31:0] got;
    wb_access(1'b0, adr, 32'd0, got);
    assert (got == exp)
      else fail_now($sformatf("%s read 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // Expected entry lines up with the result one edge after issue
  always @(posedge clk_i) begin
    if (valid_i && rst_n_i) begin
      cur_exp <= ref_q.pop_front();
    end
    chk <= valid_i && rst_n_i;
  end

  // Outputs are stable at the falling edge
  a_valid: assert property (@(negedge clk_i) disable iff (!rst_n_i) res_valid_o == chk)
    else fail_now("res_valid_o does not follow the issued stream");
  a_taken: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    chk |-> (res_taken_o == cur_exp.taken) && (res_pc_o == cur_exp.pc))
    else fail_now("wrong taken flag or result PC");
  a_target: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    chk |-> (res_target_o == cur_exp.target) && (link_o == cur_exp.link))
    else fail_now("wrong target or link address");
  a_mispredict: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    res_mispredict_o == (chk && cur_exp.mis))
    else fail_now("wrong mispredict flag");
  a_cf: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    chk |-> (res_cf_o == cur_exp.cf))
    else fail_now("wrong control-flow kind");
  a_exc: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    exc_valid_o == (chk && cur_exp.exc))
    else fail_now("wrong misaligned exception flag");
  a_tval: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    (chk && cur_exp.exc) |-> (exc_cause_o == CAUSE_INSTR_MISALIGNED) &&
                             (exc_tval_o == cur_exp.tval))
    else fail_now("wrong exception cause or trap value");

  initial begin
    logic [VLEN-1:0] a;
    logic [VLEN-1:0] b;
    logic [VLEN-1:0] r;
    logic [VLEN-1:0] imm;
    logic [VLEN-1:0] tgt;
    logic [CF_W-1:0] pcf;
    void'($urandom(32'h50f1_12ef));
    rst_n_i = 1'b0;
    // Issue and bus request stay active through reset
    valid_i = 1'b1;
    // Equal operands with no prediction make a mispredicted BEQ
    op_i = OP_BEQ;
    operand_a_i = '0;
    operand_b_i = '0;
    imm_i = '0;
    pc_i = '0;
    is_compressed_i = 1'b0;
    pred_cf_i = CF_NONE;
    pred_addr_i = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    valid_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    @(negedge clk_i);
    assert (!res_valid_o && !res_mispredict_o && !exc_valid_o && !wb_ack_o)
      else fail_now("valid or ack output high after reset");
    read_check(ADR_CTRL, 32'd3, "CTRL after reset");
    read_check(ADR_RESOLVED, 32'd0, "Resolved counter after reset");
    read_check(ADR_MISPRED, 32'd0, "Mispredict counter after reset");

    // Signed and unsigned orderings disagree on these operands
    issue(OP_BLT, 32'hffff_fff0, 32'd1, 32'd16, 32'h100, 1'b0, CF_BRANCH, 32'd0);
    issue(OP_BLTU, 32'hffff_fff0, 32'd1, 32'd16, 32'h100, 1'b0, CF_BRANCH, 32'd0);
    issue(OP_BGE, 32'hffff_fff0, 32'd1, 32'hffff_fff0, 32'h200, 1'b1, CF_NONE, 32'd0);
    issue(OP_BGEU, 32'hffff_fff0, 32'd1, 32'hffff_fff0, 32'h200, 1'b1, CF_NONE, 32'd0);
    // Back-to-back random branches with a quarter on equal operands
    for (int i = 0; i < 200; i++) begin
      a = $urandom;
      b = ($urandom_range(0, 3) == 0) ? a : $urandom;
      r = $urandom;
      imm = {{19{r[12]}}, r[12:1], 1'b0};
      pcf = r[20] ? CF_BRANCH : CF_NONE;
      issue(OP_W'($urandom_range(0, 5)), a, b, imm, $urandom & 32'hffff_fffc, r[21], pcf,
            $urandom);
    end

    // Jumps where the JALR target has bit 0 dropped
    issue(OP_JAL, 32'd0, 32'd0, 32'h100, 32'h8000_0000, 1'b0, CF_JUMP, 32'd0);
    issue(OP_JAL, 32'd0, 32'd0, 32'hffff_ff00, 32'h8000_0010, 1'b1, CF_NONE, 32'd0);
    issue(OP_JALR, 32'h1235, 32'd0, 32'd0, 32'h400, 1'b0, CF_JUMPR, 32'h1234);
    issue(OP_JALR, 32'h1235, 32'd0, 32'd0, 32'h400, 1'b1, CF_NONE, 32'h1234);
    issue(OP_JALR, 32'h1235, 32'd0, 32'd4, 32'h400, 1'b0, CF_RETURN, 32'h1234);
    issue(OP_JALR, 32'h1235, 32'd0, 32'd4, 32'h400, 1'b0, CF_RETURN, 32'h1238);
    for (int i = 0; i < 40; i++) begin
      a = $urandom;
      r = $urandom;
      imm = {{20{r[11]}}, r[11:0]};
      tgt = (a + imm) & 32'hffff_fffe;
      pcf = (r[13:12] == 2'd0) ? CF_NONE : ((r[13:12] == 2'd1) ? CF_JUMPR : CF_RETURN);
      issue(OP_JALR, a, 32'd0, imm, $urandom & 32'hffff_fffc, r[14], pcf,
            r[15] ? tgt : $urandom);
    end
    go_idle();
    wait_drain();

    // Compressed support off and trap value on
    write_ctrl(2'b10);
    read_check(ADR_CTRL, 32'd2, "CTRL with compressed off");
    issue(OP_JAL, 32'd0, 32'd0, 32'd2, 32'h1000, 1'b0, CF_JUMP, 32'd0);
    issue(OP_BEQ, 32'd1, 32'd2, 32'd6, 32'h1004, 1'b0, CF_NONE, 32'd0);
    issue(OP_BNE, 32'd1, 32'd2, 32'd6, 32'h1008, 1'b0, CF_BRANCH, 32'd0);
    issue(OP_JALR, 32'h2003, 32'd0, 32'd0, 32'h100c, 1'b0, CF_JUMPR, 32'h2002);
    issue(OP_JALR, 32'h2001, 32'd0, 32'd0, 32'h1010, 1'b0, CF_JUMPR, 32'h2000);
    issue(OP_JAL, 32'd0, 32'd0, 32'd4, 32'h1014, 1'b0, CF_JUMP, 32'd0);
    go_idle();
    wait_drain();
    // Trap value off as well
    write_ctrl(2'b00);
    read_check(ADR_CTRL, 32'd0, "CTRL with both bits off");
    issue(OP_JAL, 32'd0, 32'd0, 32'd2, 32'h3000, 1'b0, CF_JUMP, 32'd0);
    for (int i = 0; i < 30; i++) begin
      a = $urandom;
      r = $urandom;
      issue(OP_W'($urandom_range(0, 7)), a, r[0] ? a : $urandom, {{20{r[11]}}, r[11:0]},
            $urandom & 32'hffff_fffc, r[12], CF_W'($urandom_range(0, 4)), $urandom);
    end
    go_idle();
    wait_drain();
    write_ctrl(2'b11);
    read_check(ADR_CTRL, 32'd3, "CTRL restored");

    // Quiet interval lets the last counts land
    repeat (3) @(posedge clk_i);
    read_check(ADR_RESOLVED, n_resolved, "Resolved counter");
    read_check(ADR_MISPRED, n_mispred, "Mispredict counter");
    wb_access(1'b1, ADR_CLEAR, 32'd1, r);
    read_check(ADR_RESOLVED, 32'd0, "Resolved counter after clear");
    read_check(ADR_MISPRED, 32'd0, "Mispredict counter after clear");
    read_check(ADR_CLEAR, 32'd0, "Clear offset");

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== source/branch_resolve_top.sv ====
`timescale 1ns/1ps

module branch_resolve_top import branch_pkg::*, brcfg_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Issue side
  input  logic                valid_i,
  input  logic [OP_W-1:0]     op_i,
  input  logic [VLEN-1:0]     operand_a_i,
  input  logic [VLEN-1:0]     operand_b_i,
  input  logic [VLEN-1:0]     imm_i,
  input  logic [VLEN-1:0]     pc_i,
  input  logic                is_compressed_i,
  input  logic [CF_W-1:0]     pred_cf_i,
  input  logic [VLEN-1:0]     pred_addr_i,
  // Resolution
  output logic                res_valid_o,
  output logic [VLEN-1:0]     res_pc_o,
  output logic [VLEN-1:0]     res_target_o,
  output logic                res_taken_o,
  output logic                res_mispredict_o,
  output logic [CF_W-1:0]     res_cf_o,
  output logic [VLEN-1:0]     link_o,
  // Exception
  output logic                exc_valid_o,
  output logic [CAUSE_W-1:0]  exc_cause_o,
  output logic [VLEN-1:0]     exc_tval_o,
  // Wishbone register port
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [WB_ADR_W-1:0] wb_adr_i,
  input  logic [31:0]         wb_dat_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o
);

  // Comparator result into the resolver
  logic comp_res;
  // Control bits from the register block
  logic rvc_en;
  logic tval_en;

  branch_compare u_compare (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .comp_res_o  (comp_res)
  );

  branch_unit u_unit (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (valid_i),
    .op_i             (op_i),
    .operand_a_i      (operand_a_i),
    .imm_i            (imm_i),
    .pc_i             (pc_i),
    .is_compressed_i  (is_compressed_i),
    .pred_cf_i        (pred_cf_i),
    .pred_addr_i      (pred_addr_i),
    .comp_res_i       (comp_res),
    .rvc_en_i         (rvc_en),
    .tval_en_i        (tval_en),
    .res_valid_o      (res_valid_o),
    .res_pc_o         (res_pc_o),
    .res_target_o     (res_target_o),
    .res_taken_o      (res_taken_o),
    .res_mispredict_o (res_mispredict_o),
    .res_cf_o         (res_cf_o),
    .link_o           (link_o),
    .exc_valid_o      (exc_valid_o),
    .exc_cause_o      (exc_cause_o),
    .exc_tval_o       (exc_tval_o)
  );

  // Counters see the registered resolution, two cycles after issue
  branch_cfg_regs u_cfg_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .wb_cyc_i         (wb_cyc_i),
    .wb_stb_i         (wb_stb_i),
    .wb_we_i          (wb_we_i),
    .wb_adr_i         (wb_adr_i),
    .wb_dat_i         (wb_dat_i),
    .wb_dat_o         (wb_dat_o),
    .wb_ack_o         (wb_ack_o),
    .res_valid_i      (res_valid_o),
    .res_mispredict_i (res_mispredict_o),
    .rvc_en_o         (rvc_en),
    .tval_en_o        (tval_en)
  );

endmodule

// ==== source/branch_cfg_regs.sv ====
`timescale 1ns/1ps

module branch_cfg_regs import brcfg_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Wishbone classic slave
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [WB_ADR_W-1:0] wb_adr_i,
  input  logic [31:0]         wb_dat_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o,
  // Resolution events from the resolver
  input  logic                res_valid_i,
  input  logic                res_mispredict_i,
  // Control bits to the resolver
  output logic                rvc_en_o,
  output logic                tval_en_o
);

  logic              req;
  logic              wr_ctrl;
  logic              wr_clear;
  logic [CTRL_W-1:0] ctrl_q;
  logic [31:0]       resolved_q;
  logic [31:0]       mispred_q;
  logic [31:0]       rd_data;

  // New request only while ack is low, so each transfer acks once
  assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_ctrl  = req && wb_we_i && (wb_adr_i == ADR_CTRL);
  assign wr_clear = req && wb_we_i && (wb_adr_i == ADR_CLEAR);

  // Single cycle ack on the edge after the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  // Control register, written at the ack edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= CTRL_RESET;
    end else if (wr_ctrl) begin
      ctrl_q[CTRL_RVC_BIT]  <= wb_dat_i[CTRL_RVC_BIT];
      ctrl_q[CTRL_TVAL_BIT] <= wb_dat_i[CTRL_TVAL_BIT];
    end
  end

  // Event counters, wrap on overflow
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resolved_q <= '0;
      mispred_q  <= '0;
    end else if (wr_clear) begin
      // Clear beats a same-cycle count
      resolved_q <= '0;
      mispred_q  <= '0;
    end else begin
      if (res_valid_i) begin
        resolved_q <= resolved_q + 32'd1;
      end
      if (res_valid_i && res_mispredict_i) begin
        mispred_q <= mispred_q + 32'd1;
      end
    end
  end

  // Read mux, unmapped and clear offsets read zero
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      ADR_CTRL:     rd_data = {{(32 - CTRL_W){1'b0}}, ctrl_q};
      ADR_RESOLVED: rd_data = resolved_q;
      ADR_MISPRED:  rd_data = mispred_q;
      default:      rd_data = '0;
    endcase
  end

  // Capture read data so it is stable while ack is high
  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  assign rvc_en_o  = ctrl_q[CTRL_RVC_BIT];
  assign tval_en_o = ctrl_q[CTRL_TVAL_BIT];

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import branch_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Issue side, one instruction per cycle
  input  logic               valid_i,
  input  logic [OP_W-1:0]    op_i,
  input  logic [VLEN-1:0]    operand_a_i,
  input  logic [VLEN-1:0]    imm_i,
  input  logic [VLEN-1:0]    pc_i,
  input  logic               is_compressed_i,
  // Frontend prediction for this instruction
  input  logic [CF_W-1:0]    pred_cf_i,
  input  logic [VLEN-1:0]    pred_addr_i,
  // Taken result from the comparator
  input  logic               comp_res_i,
  // Control bits from the register block
  input  logic               rvc_en_i,
  input  logic               tval_en_i,
  // Resolution, one cycle after issue
  output logic               res_valid_o,
  output logic [VLEN-1:0]    res_pc_o,
  output logic [VLEN-1:0]    res_target_o,
  output logic               res_taken_o,
  output logic               res_mispredict_o,
  output logic [CF_W-1:0]    res_cf_o,
  output logic [VLEN-1:0]    link_o,
  // Misaligned target exception
  output logic               exc_valid_o,
  output logic [CAUSE_W-1:0] exc_cause_o,
  output logic [VLEN-1:0]    exc_tval_o
);

  logic            is_branch;
  logic            is_jalr;
  logic [VLEN-1:0] jump_base;
  logic [VLEN-1:0] target;
  logic [VLEN-1:0] next_pc;
  logic            mispredict;
  logic [CF_W-1:0] cf_type;
  logic            misaligned;

  // Decode the two classes that need special handling
  assign is_branch = (op_i == OP_BEQ)  || (op_i == OP_BNE)  ||
                     (op_i == OP_BLT)  || (op_i == OP_BGE)  ||
                     (op_i == OP_BLTU) || (op_i == OP_BGEU);
  assign is_jalr   = (op_i == OP_JALR);

  // JALR jumps relative to rs1, everything else relative to the PC
  assign jump_base = is_jalr ? operand_a_i : pc_i;

  always_comb begin
    // Two's complement add covers the signed immediate
    target = jump_base + imm_i;
    // JALR drops the LSB of the computed address
    if (is_jalr) begin
      target[0] = 1'b0;
    end
  end

  // Fall-through address, also written to rd
  assign next_pc = pc_i + (is_compressed_i ? VLEN'(2) : VLEN'(4));

  // Compare the outcome against the frontend speculation
  always_comb begin
    mispredict = 1'b0;
    cf_type    = pred_cf_i;
    if (is_branch) begin
      cf_type    = CF_BRANCH;
      // BHT said taken exactly when it predicted a branch
      mispredict = comp_res_i != (pred_cf_i == CF_BRANCH);
    end else if (is_jalr) begin
      if ((pred_cf_i == CF_NONE) || (pred_addr_i != target)) begin
        mispredict = 1'b1;
        // Returns keep their kind so the RAS stays in charge
        if (pred_cf_i != CF_RETURN) begin
          cf_type = CF_JUMPR;
        end
      end
    end
  end

  // Without compressed support targets must be word aligned
  assign misaligned = !rvc_en_i && comp_res_i && (target[1:0] != 2'b00);

  // Valid flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_o      <= 1'b0;
      res_mispredict_o <= 1'b0;
      exc_valid_o      <= 1'b0;
    end else begin
      res_valid_o      <= valid_i;
      res_mispredict_o <= valid_i && mispredict;
      exc_valid_o      <= valid_i && misaligned;
    end
  end

  // Payload follows each issued instruction
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_pc_o     <= pc_i;
      res_taken_o  <= comp_res_i;
      // Redirect to the target when taken, else fall through
      res_target_o <= comp_res_i ? target : next_pc;
      res_cf_o     <= cf_type;
      link_o       <= next_pc;
      exc_cause_o  <= CAUSE_INSTR_MISALIGNED;
      // Trap value reports the faulting PC if enabled
      exc_tval_o   <= tval_en_i ? pc_i : '0;
    end
  end

endmodule

// ==== source/branch_compare.sv ====
`timescale 1ns/1ps

module branch_compare import branch_pkg::*; (
  // Operation selecting the comparison
  input  logic [OP_W-1:0] op_i,
  // Register operands rs1 and rs2
  input  logic [VLEN-1:0] operand_a_i,
  input  logic [VLEN-1:0] operand_b_i,
  // Taken result for the resolver
  output logic            comp_res_o
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  // Shared comparators, each branch kind picks one
  assign equal         = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  always_comb begin
    // Unknown codes never count as taken
    comp_res_o = 1'b0;
    case (op_i)
      OP_BEQ:  comp_res_o = equal;
      OP_BNE:  comp_res_o = !equal;
      OP_BLT:  comp_res_o = less_signed;
      OP_BGE:  comp_res_o = !less_signed;
      OP_BLTU: comp_res_o = less_unsigned;
      OP_BGEU: comp_res_o = !less_unsigned;
      // Jumps are always taken
      OP_JAL:  comp_res_o = 1'b1;
      OP_JALR: comp_res_o = 1'b1;
      default: comp_res_o = 1'b0;
    endcase
  end

endmodule

// ==== source/brcfg_pkg.sv ====
package brcfg_pkg;

  // Byte address width of the register block
  localparam int unsigned WB_ADR_W = 4;

  // Register offsets
  localparam logic [WB_ADR_W-1:0] ADR_CTRL     = 4'h0;
  localparam logic [WB_ADR_W-1:0] ADR_RESOLVED = 4'h4;
  localparam logic [WB_ADR_W-1:0] ADR_MISPRED  = 4'h8;
  // Write-only, any data clears both counters
  localparam logic [WB_ADR_W-1:0] ADR_CLEAR    = 4'hC;

  // Control register layout
  localparam int unsigned CTRL_W        = 2;
  localparam int unsigned CTRL_RVC_BIT  = 0;
  localparam int unsigned CTRL_TVAL_BIT = 1;

  // Compressed support and trap values both on out of reset
  localparam logic [CTRL_W-1:0] CTRL_RESET = 2'b11;

endpackage

// ==== source/branch_pkg.sv ====
package branch_pkg;

  // Address and data width of the resolver datapath
  localparam int unsigned VLEN = 32;

  // Operation code word
  localparam int unsigned OP_W = 4;

  // Conditional branches occupy the low codes
  localparam logic [OP_W-1:0] OP_BEQ  = 4'd0;
  localparam logic [OP_W-1:0] OP_BNE  = 4'd1;
  localparam logic [OP_W-1:0] OP_BLT  = 4'd2;
  localparam logic [OP_W-1:0] OP_BGE  = 4'd3;
  localparam logic [OP_W-1:0] OP_BLTU = 4'd4;
  localparam logic [OP_W-1:0] OP_BGEU = 4'd5;
  // Unconditional jumps
  localparam logic [OP_W-1:0] OP_JAL  = 4'd6;
  localparam logic [OP_W-1:0] OP_JALR = 4'd7;

  // Control-flow kind word, shared with the frontend predictor
  localparam int unsigned CF_W = 3;

  // No control flow predicted
  localparam logic [CF_W-1:0] CF_NONE   = 3'd0;
  // Conditional branch, updates the BHT
  localparam logic [CF_W-1:0] CF_BRANCH = 3'd1;
  // Direct jump
  localparam logic [CF_W-1:0] CF_JUMP   = 3'd2;
  // Register-indirect jump, updates the BTB
  localparam logic [CF_W-1:0] CF_JUMPR  = 3'd3;
  // Function return, served by the RAS
  localparam logic [CF_W-1:0] CF_RETURN = 3'd4;

  // Exception cause word
  localparam int unsigned CAUSE_W = 4;

  // Instruction address misaligned
  localparam logic [CAUSE_W-1:0] CAUSE_INSTR_MISALIGNED = 4'd0;

endpackage
